//--- Makefile
# Verilator build and run of the MAC row testbench

VERILATOR ?= verilator
TOP       ?= mac_row_tb
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= All tests passed

SRCS := $(shell grep -v '^+' src.f)
HDRS := $(wildcard common/*.svh)
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): src.f $(SRCS) $(HDRS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f src.f --Mdir $(BUILD_DIR) -o V$(TOP)

run: $(SIM)
	@$(SIM) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

//--- common/mac_params.svh
/*
 * Size and address macros for the MAC row engine.
 * Included by the package and by every RTL file that needs a width,
 * the row height or a Wishbone register address.
 */
`ifndef MAC_PARAMS_SVH
`define MAC_PARAMS_SVH

`define MAC_HEIGHT      4   // computing elements in the row
`define MAC_OP_W        16
`define MAC_ACC_W       32
`define MAC_FIFO_DEPTH  4   // keep a power of two
`define MAC_WB_AW       5   // word address bits

// word addresses of the register map
`define MAC_ADDR_X      0   // X[0..3] at 0..3
`define MAC_ADDR_W      8   // W[0..3] at 8..11
`define MAC_ADDR_BIAS   16
`define MAC_ADDR_START  17
`define MAC_ADDR_RESULT 18
`define MAC_ADDR_STATUS 19

`endif

//--- common/mac_pkg.sv
/*
 * Shared types of the MAC row engine: operand and sum words,
 * the job handed to the row and the Wishbone request/response bundles.
 */
`include "mac_params.svh"

package mac_pkg;

  typedef logic signed [`MAC_OP_W-1:0]  operand_t;
  typedef logic signed [`MAC_ACC_W-1:0] acc_t;
  typedef logic        [`MAC_WB_AW-1:0] wb_addr_t;
  typedef logic        [31:0]           wb_data_t;

  // one dot-product job, x and w indexed by element
  typedef struct packed {
    operand_t [`MAC_HEIGHT-1:0] x;
    operand_t [`MAC_HEIGHT-1:0] w;
    acc_t                       bias;
  } row_job_t;

  typedef struct packed {
    logic       cyc;
    logic       stb;
    logic       we;
    wb_addr_t   adr;
    wb_data_t   dat;
    logic [3:0] sel;
  } wb_req_t;

  typedef struct packed {
    logic     ack;
    wb_data_t dat;
  } wb_rsp_t;

endpackage

//--- design/mac_ce.sv
/*
 * One computing element of the MAC row.
 * Forms x*w plus the incoming partial sum and holds it in a single
 * output register, advanced by en_i and cleared by flush_i.
 */
`timescale 1ns/1ps
`include "mac_params.svh"

module mac_ce (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              en_i,
  input  logic              flush_i,
  input  mac_pkg::operand_t x_i,
  input  mac_pkg::operand_t w_i,
  input  mac_pkg::acc_t     acc_i,
  output mac_pkg::acc_t     sum_o
);

  logic signed [2*`MAC_OP_W-1:0] prod;
  mac_pkg::acc_t                 prod_ext;
  mac_pkg::acc_t                 sum_d;
  mac_pkg::acc_t                 sum_q;

  // full-width signed product
  assign prod = x_i * w_i;

  // sign extended to the accumulator, sum wraps on overflow
  assign prod_ext = mac_pkg::acc_t'(prod);
  assign sum_d    = acc_i + prod_ext;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      sum_q <= '0;
    end else if (flush_i) begin
      sum_q <= '0;
    end else if (en_i) begin
      sum_q <= sum_d;
    end
  end

  assign sum_o = sum_q;

endmodule

//--- design/mac_row_top.sv
/*
 * Top level of the MAC dot-product engine.
 * Connects the Wishbone register block to the MAC row.
 */
`timescale 1ns/1ps

module mac_row_top (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  mac_pkg::wb_req_t wb_req_i,
  output mac_pkg::wb_rsp_t wb_rsp_o
);

  logic              job_valid, job_ready;
  mac_pkg::row_job_t job;
  logic              res_valid, res_ready;
  mac_pkg::acc_t     res_sum;
  logic              row_busy, row_flush;

  wb_mac_regs i_regs (
    .clk_i       ( clk_i     ),
    .rst_ni      ( rst_ni    ),
    .wb_req_i    ( wb_req_i  ),
    .wb_rsp_o    ( wb_rsp_o  ),
    .job_valid_o ( job_valid ),
    .job_ready_i ( job_ready ),
    .job_o       ( job       ),
    .res_valid_i ( res_valid ),
    .res_ready_o ( res_ready ),
    .res_sum_i   ( res_sum   ),
    .row_busy_i  ( row_busy  ),
    .row_flush_o ( row_flush )
  );

  mac_row i_row (
    .clk_i       ( clk_i     ),
    .rst_ni      ( rst_ni    ),
    .job_valid_i ( job_valid ),
    .job_ready_o ( job_ready ),
    .job_i       ( job       ),
    .flush_i     ( row_flush ),
    .res_valid_o ( res_valid ),
    .res_ready_i ( res_ready ),
    .res_sum_o   ( res_sum   ),
    .busy_o      ( row_busy  )
  );

endmodule

//--- design/wb_mac_regs.sv
/*
 * Wishbone classic slave of the MAC engine.
 * Holds the X, W and bias registers, launches jobs on a START write
 * and buffers finished sums in a small result FIFO read via RESULT.
 */
`timescale 1ns/1ps
`include "mac_params.svh"

module wb_mac_regs (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  mac_pkg::wb_req_t  wb_req_i,
  output mac_pkg::wb_rsp_t  wb_rsp_o,
  output logic              job_valid_o,
  input  logic              job_ready_i,
  output mac_pkg::row_job_t job_o,
  input  logic              res_valid_i,
  output logic              res_ready_o,
  input  mac_pkg::acc_t     res_sum_i,
  input  logic              row_busy_i,
  output logic              row_flush_o
);

  localparam int H     = `MAC_HEIGHT;
  localparam int DEPTH = `MAC_FIFO_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  typedef enum logic [1:0] {IDLE, WAIT_JOB, ACK} state_e;

  state_e            state_q, state_d;
  mac_pkg::row_job_t job_q;
  mac_pkg::wb_data_t rd_data, rdata_q;
  mac_pkg::acc_t     fifo_q [DEPTH];
  logic [PTR_W-1:0]  wr_ptr_q, rd_ptr_q;
  logic [CNT_W-1:0]  cnt_q;
  logic              req, start_wr, push, pop;

  // byte-lane merge of a write into an old value
  function automatic mac_pkg::wb_data_t merge(input mac_pkg::wb_data_t old_v,
                                              input mac_pkg::wb_data_t new_v,
                                              input logic [3:0]        sel);
    mac_pkg::wb_data_t res;
    res = old_v;
    for (int b = 0; b < 4; b++) begin
      if (sel[b]) res[8*b +: 8] = new_v[8*b +: 8];
    end
    return res;
  endfunction

  assign req         = wb_req_i.cyc & wb_req_i.stb & (state_q == IDLE);
  assign start_wr    = req & wb_req_i.we & (wb_req_i.adr == `MAC_ADDR_START);
  assign row_flush_o = start_wr & wb_req_i.dat[1];   // flush instead of a job
  assign res_ready_o = (cnt_q != CNT_W'(DEPTH));
  assign push        = res_valid_i & res_ready_o;
  assign pop         = req & ~wb_req_i.we & (wb_req_i.adr == `MAC_ADDR_RESULT) & (cnt_q != '0);
  assign job_valid_o = (state_q == WAIT_JOB);
  assign job_o       = job_q;
  assign wb_rsp_o.ack = (state_q == ACK);
  assign wb_rsp_o.dat = rdata_q;

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (req) state_d = (start_wr && !wb_req_i.dat[1]) ? WAIT_JOB : ACK;
      end
      WAIT_JOB: begin
        if (job_ready_i) state_d = ACK;   // row takes the job on this edge
      end
      default: state_d = IDLE;
    endcase
  end

  always_comb begin
    rd_data = '0;
    for (int i = 0; i < H; i++) begin
      if (wb_req_i.adr == `MAC_ADDR_X + i) rd_data = mac_pkg::wb_data_t'(job_q.x[i]);
      if (wb_req_i.adr == `MAC_ADDR_W + i) rd_data = mac_pkg::wb_data_t'(job_q.w[i]);
    end
    if (wb_req_i.adr == `MAC_ADDR_BIAS) rd_data = job_q.bias;
    if (wb_req_i.adr == `MAC_ADDR_RESULT && cnt_q != '0) rd_data = fifo_q[rd_ptr_q];
    if (wb_req_i.adr == `MAC_ADDR_STATUS) begin
      rd_data[CNT_W-1:0] = cnt_q;
      rd_data[8]         = row_busy_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
      job_q   <= '0;
      rdata_q <= '0;
    end else begin
      state_q <= state_d;
      if (req) rdata_q <= rd_data;
      if (req && wb_req_i.we) begin
        for (int i = 0; i < H; i++) begin
          if (wb_req_i.adr == `MAC_ADDR_X + i)
            job_q.x[i] <= mac_pkg::operand_t'(merge(mac_pkg::wb_data_t'(job_q.x[i]),
                                                    wb_req_i.dat, wb_req_i.sel));
          if (wb_req_i.adr == `MAC_ADDR_W + i)
            job_q.w[i] <= mac_pkg::operand_t'(merge(mac_pkg::wb_data_t'(job_q.w[i]),
                                                    wb_req_i.dat, wb_req_i.sel));
        end
        if (wb_req_i.adr == `MAC_ADDR_BIAS)
          job_q.bias <= mac_pkg::acc_t'(merge(job_q.bias, wb_req_i.dat, wb_req_i.sel));
      end
    end
  end

  // result FIFO storage
  always_ff @(posedge clk_i) begin
    if (push) fifo_q[wr_ptr_q] <= res_sum_i;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else if (row_flush_o) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push) wr_ptr_q <= wr_ptr_q + 1'b1;   // wraps, depth is a power of two
      if (pop) rd_ptr_q <= rd_ptr_q + 1'b1;
      if (push && !pop) cnt_q <= cnt_q + 1'b1;
      else if (pop && !push) cnt_q <= cnt_q - 1'b1;
    end
  end

endmodule

//--- mac_row/mac_row.sv
/*
 * Row of chained MAC computing elements.
 * Element h sees x[h] and w[h] delayed by h cycles so they meet the
 * partial sum of the same job; a valid shift chain follows the jobs.
 * The whole row stalls while a result waits on res_ready_i.
 */
`timescale 1ns/1ps
`include "mac_params.svh"

module mac_row #(
  parameter int HEIGHT = `MAC_HEIGHT
) (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              job_valid_i,
  output logic              job_ready_o,
  input  mac_pkg::row_job_t job_i,
  input  logic              flush_i,
  output logic              res_valid_o,
  input  logic              res_ready_i,
  output mac_pkg::acc_t     res_sum_o,
  output logic              busy_o
);

  logic                               row_en;
  logic              [HEIGHT-1:0]     vld_q;
  mac_pkg::operand_t [HEIGHT-1:0]     x_in;
  mac_pkg::operand_t [HEIGHT-1:0]     w_in;
  mac_pkg::acc_t     [HEIGHT-1:0]     acc_in;
  mac_pkg::acc_t     [HEIGHT-1:0]     sum;

  // stall only when the finished result cannot leave
  assign row_en      = ~(res_valid_o & ~res_ready_i);
  assign job_ready_o = row_en;

  for (genvar h = 0; h < HEIGHT; h++) begin : gen_ce
    if (h == 0) begin : gen_head
      assign x_in[h]   = job_i.x[h];
      assign w_in[h]   = job_i.w[h];
      assign acc_in[h] = job_i.bias;   // bias enters as the first partial sum
    end else begin : gen_skew
      mac_pkg::operand_t [h-1:0] x_sk;
      mac_pkg::operand_t [h-1:0] w_sk;

      always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
          x_sk <= '0;
          w_sk <= '0;
        end else if (row_en) begin
          x_sk[0] <= job_i.x[h];
          w_sk[0] <= job_i.w[h];
          for (int i = 1; i < h; i++) begin
            x_sk[i] <= x_sk[i-1];
            w_sk[i] <= w_sk[i-1];
          end
        end
      end

      assign x_in[h]   = x_sk[h-1];
      assign w_in[h]   = w_sk[h-1];
      assign acc_in[h] = sum[h-1];
    end

    mac_ce i_ce (
      .clk_i   ( clk_i     ),
      .rst_ni  ( rst_ni    ),
      .en_i    ( row_en    ),
      .flush_i ( flush_i   ),
      .x_i     ( x_in[h]   ),
      .w_i     ( w_in[h]   ),
      .acc_i   ( acc_in[h] ),
      .sum_o   ( sum[h]    )
    );
  end

  // bit h marks a live job in the register of element h
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      vld_q <= '0;
    end else if (flush_i) begin
      vld_q <= '0;
    end else if (row_en) begin
      vld_q[0] <= job_valid_i;
      for (int i = 1; i < HEIGHT; i++) begin
        vld_q[i] <= vld_q[i-1];
      end
    end
  end

  assign res_valid_o = vld_q[HEIGHT-1];
  assign res_sum_o   = sum[HEIGHT-1];
  assign busy_o      = |vld_q;

endmodule

//--- src.f
+incdir+common
common/mac_pkg.sv
design/mac_ce.sv
mac_row/mac_row.sv
design/wb_mac_regs.sv
design/mac_row_top.sv
testbench/mac_row_checker.sv
testbench/mac_row_sva.sv
testbench/mac_row_tb.sv

//--- testbench/mac_row_checker.sv
/*
 * Bus monitor for the MAC engine testbench.
 * Compares Wishbone read data against a queue of expected words
 * filled by the testbench, and prints a line per finished test.
 */
`timescale 1ns/1ps

module mac_row_checker (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  mac_pkg::wb_req_t  wb_req_i,
  input  mac_pkg::wb_rsp_t  wb_rsp_i,
  input  logic              exp_push_i,
  input  mac_pkg::wb_data_t exp_data_i,
  input  logic              test_done_i,
  input  int                test_id_i,
  output int                err_cnt_o,
  output int                chk_cnt_o,
  output int                pending_o
);

  mac_pkg::wb_data_t exp_q [$];
  int err_cnt   = 0;
  int chk_cnt   = 0;
  int test_errs = 0;
  int test_chks = 0;
  int pending   = 0;
  logic read_ack;

  // master still holds stb during the ack cycle
  assign read_ack = wb_req_i.cyc & wb_req_i.stb & ~wb_req_i.we & wb_rsp_i.ack;

  always @(posedge clk_i) begin
    mac_pkg::wb_data_t exp_v;
    if (exp_push_i) begin
      exp_q.push_back(exp_data_i);
    end
    if (rst_ni && read_ack && exp_q.size() != 0) begin
      exp_v = exp_q.pop_front();
      chk_cnt++;
      test_chks++;
      if (wb_rsp_i.dat !== exp_v) begin
        err_cnt++;
        test_errs++;
        $display("MISMATCH @%0t: read of address %0d returned %h, expected %h",
                 $time, wb_req_i.adr, wb_rsp_i.dat, exp_v);
      end
    end
    if (test_done_i) begin
      $display("test %0d done: %0d checks, %0d errors", test_id_i, test_chks, test_errs);
      test_chks = 0;
      test_errs = 0;
    end
    pending = exp_q.size();
  end

  assign err_cnt_o = err_cnt;
  assign chk_cnt_o = chk_cnt;
  assign pending_o = pending;

endmodule

//--- testbench/mac_row_sva.sv
/*
 * Protocol, FIFO and row stall assertions for the Wishbone register block.
 * Bound into every wb_mac_regs instance by the bind below.
 */
`timescale 1ns/1ps
`include "mac_params.svh"

module mac_row_sva (
  input logic                                   clk_i,
  input logic                                   rst_ni,
  input mac_pkg::wb_req_t                       wb_req_i,
  input mac_pkg::wb_rsp_t                       wb_rsp_i,
  input logic [$clog2(`MAC_FIFO_DEPTH + 1)-1:0] cnt_i,
  input logic                                   job_valid_i,
  input logic                                   res_valid_i,
  input logic                                   res_ready_i,
  input mac_pkg::acc_t                          res_sum_i,
  input logic                                   row_flush_i
);

  int unsigned fail_cnt = 0;
  logic        idle_rd;

  // read strobe while the slave is neither acking nor waiting on the row
  assign idle_rd = wb_req_i.cyc && wb_req_i.stb && !wb_req_i.we &&
                   !wb_rsp_i.ack && !job_valid_i;

  ack_needs_stb: assert property (@(posedge clk_i) disable iff (!rst_ni)
    wb_rsp_i.ack |-> (wb_req_i.cyc && wb_req_i.stb))
    else begin $error("ack without an active strobe"); fail_cnt++; end

  read_ack_next: assert property (@(posedge clk_i) disable iff (!rst_ni)
    idle_rd |=> (wb_rsp_i.ack ##1 !wb_rsp_i.ack))
    else begin $error("read not acked for exactly one cycle after the strobe"); fail_cnt++; end

  empty_result_zero: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (idle_rd && wb_req_i.adr == `MAC_ADDR_RESULT && cnt_i == '0) |=> (wb_rsp_i.dat == '0))
    else begin $error("read of an empty result FIFO returned data"); fail_cnt++; end

  fifo_in_range: assert property (@(posedge clk_i) disable iff (!rst_ni)
    cnt_i <= `MAC_FIFO_DEPTH)
    else begin $error("result FIFO count above depth"); fail_cnt++; end

  result_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (res_valid_i && !res_ready_i && !row_flush_i) |=> (res_valid_i && $stable(res_sum_i)))
    else begin $error("row result changed while the FIFO was full"); fail_cnt++; end

endmodule

bind wb_mac_regs mac_row_sva u_sva (
  .clk_i       ( clk_i       ),
  .rst_ni      ( rst_ni      ),
  .wb_req_i    ( wb_req_i    ),
  .wb_rsp_i    ( wb_rsp_o    ),
  .cnt_i       ( cnt_q       ),
  .job_valid_i ( job_valid_o ),
  .res_valid_i ( res_valid_i ),
  .res_ready_i ( res_ready_o ),
  .res_sum_i   ( res_sum_i   ),
  .row_flush_i ( row_flush_o )
);

//--- testbench/mac_row_tb.sv
/*
 * Top testbench of the MAC row engine.
 * Drives Wishbone cycles from a table of dot-product vectors and hands
 * the expected read data to mac_row_checker, which does the comparing.
 */
`timescale 1ns/1ps
`include "mac_params.svh"

module mac_row_tb;

  localparam int NUM_VEC  = 12;
  localparam int NUM_FIX  = 4;   // corner entries ahead of the random ones
  localparam int H        = `MAC_HEIGHT;
  localparam int WDOG_CYC = NUM_VEC * 60 + 200;

  localparam mac_pkg::wb_addr_t ADR_X      = `MAC_ADDR_X;
  localparam mac_pkg::wb_addr_t ADR_W      = `MAC_ADDR_W;
  localparam mac_pkg::wb_addr_t ADR_BIAS   = `MAC_ADDR_BIAS;
  localparam mac_pkg::wb_addr_t ADR_START  = `MAC_ADDR_START;
  localparam mac_pkg::wb_addr_t ADR_RESULT = `MAC_ADDR_RESULT;
  localparam mac_pkg::wb_addr_t ADR_STATUS = `MAC_ADDR_STATUS;

  typedef struct packed {
    mac_pkg::operand_t [H-1:0] x;
    mac_pkg::operand_t [H-1:0] w;
    mac_pkg::acc_t             bias;
    mac_pkg::acc_t             sum;
  } vec_t;

  logic              clk;
  logic              rst_n;
  mac_pkg::wb_req_t  wb_req;
  mac_pkg::wb_rsp_t  wb_rsp;
  logic              exp_push;
  mac_pkg::wb_data_t exp_data;
  logic              test_done;
  int                test_id;
  int                err_cnt, chk_cnt, pending;
  vec_t              tab [NUM_VEC];
  int                seed;

  mac_row_top dut (
    .clk_i    ( clk    ),
    .rst_ni   ( rst_n  ),
    .wb_req_i ( wb_req ),
    .wb_rsp_o ( wb_rsp )
  );

  mac_row_checker chk (
    .clk_i       ( clk       ),
    .rst_ni      ( rst_n     ),
    .wb_req_i    ( wb_req    ),
    .wb_rsp_i    ( wb_rsp    ),
    .exp_push_i  ( exp_push  ),
    .exp_data_i  ( exp_data  ),
    .test_done_i ( test_done ),
    .test_id_i   ( test_id   ),
    .err_cnt_o   ( err_cnt   ),
    .chk_cnt_o   ( chk_cnt   ),
    .pending_o   ( pending   )
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  initial begin
    repeat (WDOG_CYC) @(posedge clk);
    $display("timeout: run did not finish within %0d cycles", WDOG_CYC);
    $display("Some tests failed");
    $finish;
  end

  // bias plus the sum of x*w, kept to 32 bits
  function automatic mac_pkg::acc_t dot_rule(input vec_t v);
    longint acc;
    acc = longint'($signed(v.bias));
    for (int h = 0; h < H; h++) begin
      acc += longint'($signed(v.x[h])) * longint'($signed(v.w[h]));
    end
    return mac_pkg::acc_t'(acc[31:0]);
  endfunction

  task automatic build_table();
    int r;
    for (int h = 0; h < H; h++) begin
      tab[0].x[h] = mac_pkg::operand_t'(h + 1);
      tab[0].w[h] = mac_pkg::operand_t'(h + 5);
      tab[1].x[h] = 16'h8000;
      tab[1].w[h] = 16'h8000;
      tab[2].x[h] = 16'h8000;
      tab[2].w[h] = 16'h7fff;
      tab[3].x[h] = 16'h7fff;
      tab[3].w[h] = mac_pkg::operand_t'(h - 32768);
    end
    tab[0].bias = 32'd10;
    tab[1].bias = 32'h7fff_0000;   // products alone reach 2^32
    tab[2].bias = 32'h8000_0000;
    tab[3].bias = 32'hffff_ffff;
    for (int i = NUM_FIX; i < NUM_VEC; i++) begin
      for (int h = 0; h < H; h++) begin
        r = $random(seed);
        tab[i].x[h] = mac_pkg::operand_t'(r);
        r = $random(seed);
        tab[i].w[h] = mac_pkg::operand_t'(r);
      end
      tab[i].bias = $random(seed);
    end
    for (int i = 0; i < NUM_VEC; i++) begin
      tab[i].sum = dot_rule(tab[i]);
    end
  endtask

  // called on a falling edge, returns on one
  task automatic wb_write(input mac_pkg::wb_addr_t adr, input mac_pkg::wb_data_t dat);
    wb_req.cyc = 1'b1;
    wb_req.stb = 1'b1;
    wb_req.we  = 1'b1;
    wb_req.adr = adr;
    wb_req.dat = dat;
    wb_req.sel = 4'hf;
    @(negedge clk);
    while (!wb_rsp.ack) @(negedge clk);
    @(negedge clk);   // ack sampled on the rising edge in between
    wb_req.cyc = 1'b0;
    wb_req.stb = 1'b0;
    wb_req.we  = 1'b0;
  endtask

  task automatic wb_read(input mac_pkg::wb_addr_t adr, output mac_pkg::wb_data_t dat);
    wb_req.cyc = 1'b1;
    wb_req.stb = 1'b1;
    wb_req.we  = 1'b0;
    wb_req.adr = adr;
    wb_req.sel = 4'hf;
    @(negedge clk);
    while (!wb_rsp.ack) @(negedge clk);
    dat = wb_rsp.dat;
    @(negedge clk);
    wb_req.cyc = 1'b0;
    wb_req.stb = 1'b0;
  endtask

  task automatic expect_read(input mac_pkg::wb_addr_t adr, input mac_pkg::wb_data_t exp_v);
    mac_pkg::wb_data_t d;
    exp_push = 1'b1;
    exp_data = exp_v;
    @(negedge clk);
    exp_push = 1'b0;
    wb_read(adr, d);
  endtask

  // X and W hold 16 bits and read back sign extended
  task automatic reg_roundtrip(input mac_pkg::wb_addr_t adr, input mac_pkg::wb_data_t dat);
    mac_pkg::wb_data_t exp_v;
    exp_v = (adr == ADR_BIAS) ? dat : {{16{dat[15]}}, dat[15:0]};
    wb_write(adr, dat);
    expect_read(adr, exp_v);
  endtask

  task automatic load_vec(input vec_t v);
    for (int h = 0; h < H; h++) begin
      wb_write(ADR_X + mac_pkg::wb_addr_t'(h), 32'(v.x[h]));
      wb_write(ADR_W + mac_pkg::wb_addr_t'(h), 32'(v.w[h]));
    end
    wb_write(ADR_BIAS, v.bias);
  endtask

  task automatic wait_result();
    mac_pkg::wb_data_t st;
    st = '0;
    while (st[2:0] == 3'd0) wb_read(ADR_STATUS, st);
  endtask

  task automatic finish_test();
    test_done = 1'b1;
    @(negedge clk);
    test_done = 1'b0;
    test_id++;
  endtask

  initial begin
    int idx;
    rst_n     = 1'b0;
    wb_req    = '0;
    exp_push  = 1'b0;
    exp_data  = '0;
    test_done = 1'b0;
    test_id   = 1;
    seed      = 32'h208d3284;
    build_table();
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    expect_read(ADR_STATUS, 32'h0);
    expect_read(ADR_RESULT, 32'h0);
    finish_test();

    reg_roundtrip(ADR_X, 32'habcd_8001);
    reg_roundtrip(ADR_X + 5'd1, 32'h0000_7ffe);
    reg_roundtrip(ADR_W + 5'd2, 32'h5555_c000);
    reg_roundtrip(ADR_W + 5'd3, 32'h1234_ffff);
    reg_roundtrip(ADR_BIAS, 32'h8000_0001);
    finish_test();

    for (int i = 0; i < NUM_VEC; i++) begin
      load_vec(tab[i]);
      wb_write(ADR_START, 32'h1);
      wait_result();
      expect_read(ADR_RESULT, tab[i].sum);
    end
    finish_test();

    // jobs queue up in the FIFO, the last two starts back to back
    for (int i = 4; i < 7; i++) begin
      load_vec(tab[i]);
      wb_write(ADR_START, 32'h1);
    end
    wb_write(ADR_START, 32'h1);
    for (int k = 0; k < 4; k++) begin
      idx = (k < 3) ? 4 + k : 6;
      wait_result();
      expect_read(ADR_RESULT, tab[idx].sum);
    end
    finish_test();

    // fifth and sixth job wait in the stalled row
    for (int i = 7; i < 12; i++) begin
      load_vec(tab[i]);
      wb_write(ADR_START, 32'h1);
    end
    wb_write(ADR_START, 32'h1);
    expect_read(ADR_STATUS, 32'h100 | 32'(`MAC_FIFO_DEPTH));
    for (int k = 0; k < 6; k++) begin
      idx = (k < 5) ? 7 + k : 11;
      wait_result();
      expect_read(ADR_RESULT, tab[idx].sum);
    end
    finish_test();

    load_vec(tab[1]);
    wb_write(ADR_START, 32'h1);
    wait_result();
    expect_read(ADR_RESULT, tab[1].sum);
    wb_write(ADR_START, 32'h1);
    wb_write(ADR_START, 32'h1);
    wb_write(ADR_START, 32'h2);   // flush row and FIFO
    expect_read(ADR_STATUS, 32'h0);
    expect_read(ADR_RESULT, 32'h0);
    finish_test();

    @(negedge clk);
    $display("summary: %0d checks, %0d mismatches, %0d unanswered reads, %0d assertion failures",
             chk_cnt, err_cnt, pending, dut.i_regs.u_sva.fail_cnt);
    if (err_cnt == 0 && pending == 0 && chk_cnt > 0 && dut.i_regs.u_sva.fail_cnt == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule
